// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_uart_block_echo
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: block_echo_ctrl.sv
// ------------------------------------------------
// block echo controller
// reads a full block in address order and paces
// it out byte by byte on the transmitter done pulse
// ------------------------------------------------
`timescale 1ns/1ps

module block_echo_ctrl #(
    parameter int BLOCK_BYTES = 128
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           block_ready,
    output logic [$clog2(BLOCK_BYTES)-1:0] rd_addr,
    input  uart_echo_pkg::byte_t           rd_data,
    output logic                           consume,
    output logic                           tx_start,
    output uart_echo_pkg::byte_t           tx_byte,
    input  logic                           tx_active,
    input  logic                           tx_done
);
    import uart_echo_pkg::*;

    localparam int ADDR_W = $clog2(BLOCK_BYTES);
    localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(BLOCK_BYTES - 1);

    ctrl_state_e state;

    // ------------------------------------------------
    // control FSM
    // ------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= CTRL_WAIT_BLOCK;
            rd_addr  <= '0;
            tx_start <= 1'b0;
            consume  <= 1'b0;
        end else begin
            tx_start <= 1'b0;  // pulses by default
            consume  <= 1'b0;

            case (state)
                CTRL_WAIT_BLOCK: begin
                    if (block_ready) begin
                        rd_addr <= '0;
                        state   <= CTRL_READ;
                    end
                end

                // rd_data valid this cycle, tx_byte latches it
                CTRL_READ: begin
                    state <= CTRL_SEND;
                end

                CTRL_SEND: begin
                    if (!tx_active) begin
                        tx_start <= 1'b1;
                        state    <= CTRL_WAIT_DONE;
                    end
                end

                CTRL_WAIT_DONE: begin
                    if (tx_done) begin
                        if (rd_addr == ADDR_LAST) begin
                            state <= CTRL_CONSUME;
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                            state   <= CTRL_READ;
                        end
                    end
                end

                CTRL_CONSUME: begin
                    consume <= 1'b1;  // frees buffer, clears overrun
                    state   <= CTRL_WAIT_CLEAR;
                end

                // block_ready drops the cycle after consume
                CTRL_WAIT_CLEAR: begin
                    if (!block_ready) state <= CTRL_WAIT_BLOCK;
                end

                default: state <= CTRL_WAIT_BLOCK;
            endcase
        end
    end

    // ------------------------------------------------
    // outgoing byte
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == CTRL_READ) tx_byte <= rd_data;
    end

    // never start over a frame still on the wire
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (rst) tx_start |-> !tx_active
    ) else $error("tx_start raised while transmitter busy");

endmodule

// File: block_rx_buffer.sv
// ------------------------------------------------
// block receive buffer
// fills BLOCK_BYTES bytes from the uart receiver,
// flags overrun while full, read port is async
// ------------------------------------------------
`timescale 1ns/1ps

module block_rx_buffer #(
    parameter int CLKS_PER_BIT = 868,
    parameter int BLOCK_BYTES  = 128
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rxd,
    input  logic                           consume,
    input  logic [$clog2(BLOCK_BYTES)-1:0] rd_addr,
    output uart_echo_pkg::byte_t           rd_data,
    output logic                           block_ready,
    output logic                           overrun
);
    import uart_echo_pkg::*;

    localparam int ADDR_W = $clog2(BLOCK_BYTES);
    localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(BLOCK_BYTES - 1);

    byte_t             mem [BLOCK_BYTES];
    logic              rx_done;
    byte_t             rx_byte;
    logic [ADDR_W-1:0] wr_ptr;
    logic              wr_en;

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_rx (
        .clk     (clk),
        .rst     (rst),
        .rxd     (rxd),
        .rx_done (rx_done),
        .rx_byte (rx_byte)
    );

    assign wr_en   = rx_done && !block_ready;
    assign rd_data = mem[rd_addr];

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= rx_byte;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr      <= '0;
            block_ready <= 1'b0;
            overrun     <= 1'b0;
        end else begin
            if (consume) begin
                wr_ptr      <= '0;
                block_ready <= 1'b0;
                overrun     <= 1'b0;
            end
            if (wr_en) begin
                if (wr_ptr == ADDR_LAST) block_ready <= 1'b1;  // block complete
                else wr_ptr <= wr_ptr + 1'b1;
            end else if (rx_done) begin
                overrun <= 1'b1;  // byte dropped, sticky until consume
            end
        end
    end

    // full block is frozen until the controller releases it
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (rst)
        block_ready && !consume |=> block_ready && $stable(wr_ptr)
    ) else $error("block buffer changed while full");

endmodule

// File: filelist.f
uart_echo_pkg.sv
uart_rx.sv
uart_tx.sv
block_rx_buffer.sv
block_echo_ctrl.sv
uart_block_echo_top.sv
tb_uart_block_echo.sv

// File: tb_uart_block_echo.sv
// ------------------------------------------------
// uart block echo testbench
// serial driver, txd monitor, reference model and
// byte compare for the block echo path
// ------------------------------------------------
`timescale 1ns/1ps

module tb_uart_block_echo;

    localparam int CLKS_PER_BIT = 16;
    localparam int BLOCK_BYTES  = 8;
    localparam int N_EXTRA      = 3;    // bytes sent into a full block
    localparam int MAX_GAP      = 24;   // idle clocks between input frames
    localparam int N_BLOCKS     = 7;    // blocks over all tests
    localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
    localparam int LIMIT = (2 * N_BLOCKS * BLOCK_BYTES + N_EXTRA) * FRAME_CLKS
                         + 3 * BLOCK_BYTES * MAX_GAP + 4000;

    logic clk;
    logic rst;
    logic rxd;
    logic txd;
    logic overrun;

    integer seed        = 90382;
    int     cycle_count = 0;
    int     error_count = 0;
    int     check_count = 0;
    int     test_count  = 0;
    int     test_errors = 0;  // error count when the test began
    int     exp_total   = 0;  // accepted input bytes so far
    int     out_pos     = 0;  // output bytes compared so far

    logic [7:0] sent_q[$];     // every byte driven on rxd
    bit         dropped_q[$];  // set for bytes sent into a full block
    logic [7:0] rx_q[$];       // bytes decoded from txd

    uart_block_echo_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .BLOCK_BYTES  (BLOCK_BYTES)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .rxd     (rxd),
        .txd     (txd),
        .overrun (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog
    initial begin
        while (cycle_count < LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", LIMIT);
        $display("Some tests failed");
        $finish;
    end

    // ------------------------------------------------
    // reference model and checks
    // ------------------------------------------------
    // n-th accepted input byte, overrun bytes skipped
    function automatic logic [7:0] expected_byte(int pos);
        int k;
        k = 0;
        for (int i = 0; i < sent_q.size(); i++) begin
            if (!dropped_q[i]) begin
                if (k == pos) return sent_q[i];
                k++;
            end
        end
        return 8'h00;
    endfunction

    task automatic check(string name, logic [7:0] got, logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH %s: got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic finish_test(string name);
        test_count++;
        if (error_count == test_errors)
            $display("test %0d %s: ok", test_count, name);
        else
            $display("test %0d %s: %0d errors", test_count, name, error_count - test_errors);
        test_errors = error_count;
    endtask

    // ------------------------------------------------
    // serial driver, 8N1 on the falling edge
    // ------------------------------------------------
    task automatic send_byte(logic [7:0] b, bit dropped);
        sent_q.push_back(b);
        dropped_q.push_back(dropped);
        if (!dropped) exp_total++;
        @(negedge clk);
        rxd = 1'b0;  // start bit
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rxd = b[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rxd = 1'b1;  // stop bit
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic send_block(int max_gap);
        int gap;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            send_byte(8'($random(seed)), 1'b0);
            if (max_gap > 0) begin
                gap = {$random(seed)} % max_gap;
                repeat (gap) @(negedge clk);
            end
        end
    endtask

    // all accepted bytes back, then room for stop bit and consume
    task automatic wait_echo();
        while (out_pos < exp_total) @(negedge clk);
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    // ------------------------------------------------
    // txd monitor and compare
    // ------------------------------------------------
    initial begin : txd_monitor
        logic [7:0] b;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (txd === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);  // mid start bit
                if (txd !== 1'b0) begin
                    error_count++;
                    $display("start bit on txd ended before mid-bit");
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    b[i] = txd;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (txd !== 1'b1) begin
                    error_count++;
                    $display("stop bit on txd was not high");
                end
                rx_q.push_back(b);
            end
        end
    end

    initial begin : compare
        logic [7:0] got;
        forever begin
            @(posedge clk);
            if (rx_q.size() > 0) begin
                got = rx_q.pop_front();
                if (out_pos >= exp_total) begin
                    error_count++;
                    $display("byte 0x%02h on txd with no accepted input left", got);
                end else begin
                    check("txd byte", got, expected_byte(out_pos));
                end
                out_pos++;
            end
        end
    end

    // ------------------------------------------------
    // tests
    // ------------------------------------------------
    initial begin : main
        rst = 1'b1;
        rxd = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // idle line, nothing should move
        repeat (4 * CLKS_PER_BIT) begin
            @(negedge clk);
            check("txd", 8'(txd), 8'h01);
            check("overrun", 8'(overrun), 8'h00);
        end
        finish_test("reset state");

        send_block(0);
        wait_echo();
        check("overrun", 8'(overrun), 8'h00);
        finish_test("single block echo");

        repeat (3) begin
            send_block(MAX_GAP);
            wait_echo();
        end
        check("overrun", 8'(overrun), 8'h00);
        finish_test("back-to-back blocks");

        // extra bytes land while the block is full
        send_block(0);
        for (int i = 0; i < N_EXTRA; i++) send_byte(8'($random(seed)), 1'b1);
        check("overrun", 8'(overrun), 8'h01);
        wait_echo();
        send_byte(8'($random(seed)), 1'b0);
        check("overrun", 8'(overrun), 8'h00);  // cleared by consume
        for (int i = 1; i < BLOCK_BYTES; i++) send_byte(8'($random(seed)), 1'b0);
        wait_echo();
        finish_test("overrun");

        // short low pulse, well under the half-bit check
        @(negedge clk);
        rxd = 1'b0;
        repeat (CLKS_PER_BIT / 4 - 1) @(negedge clk);
        rxd = 1'b1;
        repeat (2 * CLKS_PER_BIT) @(negedge clk);
        send_block(0);
        wait_echo();
        check("overrun", 8'(overrun), 8'h00);
        finish_test("glitch rejection");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: uart_block_echo_top.sv
// ------------------------------------------------
// uart block echo top
// receive buffer, echo controller and transmitter
// ------------------------------------------------
`timescale 1ns/1ps

module uart_block_echo_top #(
    parameter int CLKS_PER_BIT = 868,  // 100 MHz at 115200 baud
    parameter int BLOCK_BYTES  = 128
) (
    input  logic clk,
    input  logic rst,
    input  logic rxd,
    output logic txd,
    output logic overrun
);
    import uart_echo_pkg::*;

    // buffer <-> controller
    logic                           block_ready;
    logic                           consume;
    logic [$clog2(BLOCK_BYTES)-1:0] rd_addr;
    byte_t                          rd_data;

    // controller <-> transmitter
    logic  tx_start;
    byte_t tx_byte;
    logic  tx_active;
    logic  tx_done;

    block_rx_buffer #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .BLOCK_BYTES  (BLOCK_BYTES)
    ) u_buf (
        .clk         (clk),
        .rst         (rst),
        .rxd         (rxd),
        .consume     (consume),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .block_ready (block_ready),
        .overrun     (overrun)
    );

    block_echo_ctrl #(
        .BLOCK_BYTES (BLOCK_BYTES)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .block_ready (block_ready),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .consume     (consume),
        .tx_start    (tx_start),
        .tx_byte     (tx_byte),
        .tx_active   (tx_active),
        .tx_done     (tx_done)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_tx (
        .clk       (clk),
        .rst       (rst),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .tx_active (tx_active),
        .tx_done   (tx_done),
        .txd       (txd)
    );

endmodule

// File: uart_echo_pkg.sv
// ------------------------------------------------
// uart block echo shared definitions
// data byte type, 8N1 frame size, frame and
// controller state encodings
// ------------------------------------------------
package uart_echo_pkg;

    // ------------------------------------------------
    // serial frame
    // ------------------------------------------------
    localparam int DATA_BITS = 8;                 // 8N1, no parity
    localparam int BIT_IDX_W = $clog2(DATA_BITS);  // data bit index width

    // one serial data byte
    typedef logic [DATA_BITS-1:0] byte_t;

    // frame walk shared by receiver and transmitter
    typedef enum logic [2:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP,
        UART_DONE       // one cycle, done pulse
    } uart_state_e;

    // ------------------------------------------------
    // block echo controller
    // ------------------------------------------------
    typedef enum logic [2:0] {
        CTRL_WAIT_BLOCK,    // buffer filling
        CTRL_READ,          // fetch byte at rd_addr
        CTRL_SEND,          // start tx once idle
        CTRL_WAIT_DONE,     // byte on the wire
        CTRL_CONSUME,       // release the buffer
        CTRL_WAIT_CLEAR     // block_ready going low
    } ctrl_state_e;

endpackage

// File: uart_rx.sv
// ------------------------------------------------
// uart receiver, 8N1
// two-flop input sync, start bit confirmed at
// half bit, data sampled mid-bit, LSB first
// ------------------------------------------------
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rxd,
    output logic                 rx_done,
    output uart_echo_pkg::byte_t rx_byte
);
    import uart_echo_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'((CLKS_PER_BIT - 1) / 2);
    localparam logic [BIT_IDX_W-1:0] BIT_LAST = BIT_IDX_W'(DATA_BITS - 1);

    uart_state_e          state;
    logic                 rxd_meta;
    logic                 rxd_sync;
    logic [CNT_W-1:0]     clk_cnt;
    logic [BIT_IDX_W-1:0] bit_idx;
    logic                 sample;
    byte_t                shift_q;

    assign sample  = (state == UART_DATA) && (clk_cnt == CNT_LAST);
    assign rx_done = (state == UART_DONE);
    assign rx_byte = shift_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_meta <= 1'b1;  // line idles high
            rxd_sync <= 1'b1;
            state    <= UART_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            case (state)
                UART_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rxd_sync) state <= UART_START;
                end
                UART_START: begin
                    if (clk_cnt == CNT_HALF) begin
                        clk_cnt <= '0;
                        // still low at mid-bit, else it was a glitch
                        state   <= rxd_sync ? UART_IDLE : UART_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                UART_DATA: begin
                    if (clk_cnt == CNT_LAST) begin
                        clk_cnt <= '0;
                        if (bit_idx == BIT_LAST) state <= UART_STOP;
                        else bit_idx <= bit_idx + 1'b1;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                UART_STOP: begin
                    // stop level is not checked
                    if (clk_cnt == CNT_LAST) begin
                        clk_cnt <= '0;
                        state   <= UART_DONE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= UART_IDLE;  // UART_DONE lasts one cycle
            endcase
        end
    end

    // LSB arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if (sample) shift_q <= {rxd_sync, shift_q[DATA_BITS-1:1]};
    end

    a_rx_done_pulse: assert property (
        @(posedge clk) disable iff (rst) rx_done |=> !rx_done
    ) else $error("rx_done held for more than one cycle");

endmodule

// File: uart_tx.sv
// ------------------------------------------------
// uart transmitter, 8N1
// one frame per start pulse, LSB first
// ------------------------------------------------
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx_start,
    input  uart_echo_pkg::byte_t tx_byte,
    output logic                 tx_active,
    output logic                 tx_done,
    output logic                 txd
);
    import uart_echo_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_IDX_W-1:0] BIT_LAST = BIT_IDX_W'(DATA_BITS - 1);

    uart_state_e          state;
    logic [CNT_W-1:0]     clk_cnt;
    logic [BIT_IDX_W-1:0] bit_idx;
    logic                 bit_end;
    byte_t                data_q;  // shifts right as bits go out

    assign bit_end   = (clk_cnt == CNT_LAST);
    assign tx_active = (state == UART_START) || (state == UART_DATA) || (state == UART_STOP);
    assign tx_done   = (state == UART_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= UART_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            case (state)
                UART_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    txd     <= 1'b1;
                    if (tx_start) begin
                        txd   <= 1'b0;  // start bit next cycle
                        state <= UART_START;
                    end
                end
                UART_START, UART_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        if (state == UART_START) begin
                            txd   <= data_q[0];
                            state <= UART_DATA;
                        end else if (bit_idx == BIT_LAST) begin
                            txd   <= 1'b1;  // stop bit
                            state <= UART_STOP;
                        end else begin
                            txd     <= data_q[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                UART_STOP: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        state   <= UART_DONE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // latch on start, then drop one bit per data bit sent
    always_ff @(posedge clk) begin
        if (state == UART_IDLE && tx_start) data_q <= tx_byte;
        else if (bit_end && state != UART_STOP) data_q <= data_q >> 1;
    end

    a_tx_done_pulse: assert property (
        @(posedge clk) disable iff (rst) tx_done |=> !tx_done
    ) else $error("tx_done is not a single-cycle pulse");

endmodule
